// ==== hw/soc_ctrl_map_pkg.sv ====
//****************************************
// SoC control register map
// word indices, register ids, decoded access
//****************************************
package soc_ctrl_map_pkg;

   typedef logic [11:0] paddr_t;    // 4 KB APB window
   typedef logic [31:0] word_t;
   typedef logic [6:0]  reg_idx_t;  // paddr[8:2]

   localparam reg_idx_t IDX_INFO         = 7'h00;
   localparam reg_idx_t IDX_FCBOOT       = 7'h01;
   localparam reg_idx_t IDX_FCFETCH      = 7'h02;
   localparam reg_idx_t IDX_PADFUN_BASE  = 7'h04;  // four words
   localparam reg_idx_t IDX_PADCFG_BASE  = 7'h08;  // sixteen words
   localparam reg_idx_t IDX_CLUSTER_CTRL = 7'h1C;
   localparam reg_idx_t IDX_JTAGREG      = 7'h1D;
   localparam reg_idx_t IDX_CLUSTER_IRQ  = 7'h1F;
   localparam reg_idx_t IDX_CL_BOOT0     = 7'h20;
   localparam reg_idx_t IDX_CL_BOOT1     = 7'h21;
   localparam reg_idx_t IDX_CORESTATUS   = 7'h28;
   localparam reg_idx_t IDX_CS_RO        = 7'h30;
   localparam reg_idx_t IDX_CLKSEL       = 7'h32;

   localparam reg_idx_t N_PADFUN_REGS    = 7'd4;
   localparam reg_idx_t N_PADCFG_REGS    = 7'd16;

   typedef enum logic [3:0] {
      NONE,
      INFO,
      FCBOOT,
      FCFETCH,
      PADFUN,
      PADCFG,
      CLUSTER_CTRL,
      JTAGREG,
      CLUSTER_IRQ,
      CL_BOOT0,
      CL_BOOT1,
      CORESTATUS,
      CS_RO,
      CLKSEL
   } reg_id_e;

   typedef struct packed {
      reg_id_e    id;
      logic [3:0] group;  // word offset inside a pad range
      logic       wr;
      word_t      wdata;
   } reg_access_t;

endpackage

// ==== hw/soc_ctrl_cfg_pkg.sv ====
//****************************************
// SoC control output types and resets
//****************************************
package soc_ctrl_cfg_pkg;

   localparam int N_PADS           = 64;
   localparam int PADS_PER_FUN_REG = 16;
   localparam int PADS_PER_CFG_REG = 4;

   typedef logic [1:0] pad_fun_t;

   // electrical settings of one pin, bit 0 is pull-up
   typedef struct packed {
      logic [1:0] drive;
      logic       slew_lim;
      logic       schmitt;
      logic       pull_down;
      logic       pull_up;
   } pad_cfg_t;

   // same order as the register bits 3..0
   typedef struct packed {
      logic rstn;
      logic fetch_enable;
      logic pow;
      logic byp;
   } cluster_ctrl_t;

   typedef logic [7:0]  jtag_reg_t;
   typedef logic [63:0] boot_addr_t;

   localparam logic [15:0] NB_CORES    = 16'd4;
   localparam logic [15:0] NB_CLUSTERS = 16'd0;

   localparam logic [31:0]   FC_BOOT_RESET      = 32'h1A00_0000;
   localparam pad_cfg_t      PAD_CFG_RESET      = 6'h3F;
   localparam cluster_ctrl_t CLUSTER_CTRL_RESET = 4'b1001;  // rstn and byp set

endpackage

// ==== hw/apb_reg_decode.sv ====
//****************************************
// APB register decoder
// builds one register access, merges reads
//****************************************
module apb_reg_decode
(
   input  soc_ctrl_map_pkg::paddr_t      paddr_i,
   input  soc_ctrl_map_pkg::word_t       pwdata_i,
   input  logic                          pwrite_i,
   input  logic                          psel_i,
   input  logic                          penable_i,
   input  soc_ctrl_map_pkg::word_t       pad_rdata_i,
   input  soc_ctrl_map_pkg::word_t       boot_rdata_i,
   input  soc_ctrl_map_pkg::word_t       status_rdata_i,
   output soc_ctrl_map_pkg::reg_access_t access_o,
   output soc_ctrl_map_pkg::word_t       prdata_o
);

   soc_ctrl_map_pkg::reg_idx_t idx;
   soc_ctrl_map_pkg::reg_idx_t fun_off;
   soc_ctrl_map_pkg::reg_idx_t cfg_off;

   assign idx     = paddr_i[8:2];
   assign fun_off = idx - soc_ctrl_map_pkg::IDX_PADFUN_BASE;  // wraps below base
   assign cfg_off = idx - soc_ctrl_map_pkg::IDX_PADCFG_BASE;

   always_comb
   begin
      access_o.id    = soc_ctrl_map_pkg::NONE;
      access_o.group = '0;
      if (fun_off < soc_ctrl_map_pkg::N_PADFUN_REGS)
      begin
         access_o.id    = soc_ctrl_map_pkg::PADFUN;
         access_o.group = fun_off[3:0];
      end
      else if (cfg_off < soc_ctrl_map_pkg::N_PADCFG_REGS)
      begin
         access_o.id    = soc_ctrl_map_pkg::PADCFG;
         access_o.group = cfg_off[3:0];
      end
      else
      begin
         case (idx)
            soc_ctrl_map_pkg::IDX_INFO:         access_o.id = soc_ctrl_map_pkg::INFO;
            soc_ctrl_map_pkg::IDX_FCBOOT:       access_o.id = soc_ctrl_map_pkg::FCBOOT;
            soc_ctrl_map_pkg::IDX_FCFETCH:      access_o.id = soc_ctrl_map_pkg::FCFETCH;
            soc_ctrl_map_pkg::IDX_CLUSTER_CTRL: access_o.id = soc_ctrl_map_pkg::CLUSTER_CTRL;
            soc_ctrl_map_pkg::IDX_JTAGREG:      access_o.id = soc_ctrl_map_pkg::JTAGREG;
            soc_ctrl_map_pkg::IDX_CLUSTER_IRQ:  access_o.id = soc_ctrl_map_pkg::CLUSTER_IRQ;
            soc_ctrl_map_pkg::IDX_CL_BOOT0:     access_o.id = soc_ctrl_map_pkg::CL_BOOT0;
            soc_ctrl_map_pkg::IDX_CL_BOOT1:     access_o.id = soc_ctrl_map_pkg::CL_BOOT1;
            soc_ctrl_map_pkg::IDX_CORESTATUS:   access_o.id = soc_ctrl_map_pkg::CORESTATUS;
            soc_ctrl_map_pkg::IDX_CS_RO:        access_o.id = soc_ctrl_map_pkg::CS_RO;
            soc_ctrl_map_pkg::IDX_CLKSEL:       access_o.id = soc_ctrl_map_pkg::CLKSEL;
            default:                            access_o.id = soc_ctrl_map_pkg::NONE;
         endcase
      end
   end

   assign access_o.wr    = psel_i & penable_i & pwrite_i;  // access phase only
   assign access_o.wdata = pwdata_i;

   // banks return zero for ids they do not own
   assign prdata_o = pad_rdata_i | boot_rdata_i | status_rdata_i;

endmodule

// ==== hw/pad_ctrl_regs.sv ====
//****************************************
// pad control registers
// function select and settings, 64 pins
//****************************************
module pad_ctrl_regs
(
   input  logic                          HCLK,
   input  logic                          HRESETn,
   input  soc_ctrl_map_pkg::reg_access_t access_i,
   output soc_ctrl_map_pkg::word_t       rdata_o,
   output soc_ctrl_cfg_pkg::pad_fun_t [soc_ctrl_cfg_pkg::N_PADS-1:0] pad_mux_o,
   output soc_ctrl_cfg_pkg::pad_cfg_t [soc_ctrl_cfg_pkg::N_PADS-1:0] pad_cfg_o
);

   soc_ctrl_cfg_pkg::pad_fun_t [soc_ctrl_cfg_pkg::N_PADS-1:0] pad_mux_q;
   soc_ctrl_cfg_pkg::pad_cfg_t [soc_ctrl_cfg_pkg::N_PADS-1:0] pad_cfg_q;

   logic [5:0] fun_base;  // first pin of the addressed function word
   logic [5:0] cfg_base;  // first pin of the addressed config word
   logic       fun_sel;
   logic       cfg_sel;

   assign fun_base = 6'(soc_ctrl_cfg_pkg::PADS_PER_FUN_REG * access_i.group);
   assign cfg_base = 6'(soc_ctrl_cfg_pkg::PADS_PER_CFG_REG * access_i.group);
   assign fun_sel  = (access_i.id == soc_ctrl_map_pkg::PADFUN);
   assign cfg_sel  = (access_i.id == soc_ctrl_map_pkg::PADCFG);

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         pad_mux_q <= '0;
         pad_cfg_q <= {soc_ctrl_cfg_pkg::N_PADS{soc_ctrl_cfg_pkg::PAD_CFG_RESET}};
      end
      else if (access_i.wr)
      begin
         if (fun_sel)
         begin
            for (int k = 0; k < soc_ctrl_cfg_pkg::PADS_PER_FUN_REG; k++)
            begin
               pad_mux_q[fun_base + 6'(k)] <= access_i.wdata[2*k +: 2];  // 2 bits per pin
            end
         end
         if (cfg_sel)
         begin
            for (int k = 0; k < soc_ctrl_cfg_pkg::PADS_PER_CFG_REG; k++)
            begin
               pad_cfg_q[cfg_base + 6'(k)] <= access_i.wdata[8*k +: 6];  // one byte per pin
            end
         end
      end
   end

   always_comb
   begin
      rdata_o = '0;
      if (fun_sel)
      begin
         for (int k = 0; k < soc_ctrl_cfg_pkg::PADS_PER_FUN_REG; k++)
         begin
            rdata_o[2*k +: 2] = pad_mux_q[fun_base + 6'(k)];
         end
      end
      else if (cfg_sel)
      begin
         for (int k = 0; k < soc_ctrl_cfg_pkg::PADS_PER_CFG_REG; k++)
         begin
            rdata_o[8*k +: 8] = {2'b00, pad_cfg_q[cfg_base + 6'(k)]};  // top two bits unused
         end
      end
   end

   assign pad_mux_o = pad_mux_q;
   assign pad_cfg_o = pad_cfg_q;

endmodule

// ==== hw/boot_cluster_regs.sv ====
//****************************************
// FC boot and cluster control registers
//****************************************
module boot_cluster_regs
(
   input  logic                            HCLK,
   input  logic                            HRESETn,
   input  soc_ctrl_map_pkg::reg_access_t   access_i,
   output soc_ctrl_map_pkg::word_t         rdata_o,
   output soc_ctrl_map_pkg::word_t         fc_bootaddr_o,
   output logic                            fc_fetchen_o,
   output soc_ctrl_cfg_pkg::cluster_ctrl_t cluster_ctrl_o,
   output soc_ctrl_cfg_pkg::boot_addr_t    cluster_boot_addr_o,
   output logic                            cluster_irq_o
);

   soc_ctrl_map_pkg::word_t         fc_bootaddr_q;
   logic                            fc_fetchen_q;
   soc_ctrl_cfg_pkg::cluster_ctrl_t cluster_ctrl_q;
   soc_ctrl_cfg_pkg::boot_addr_t    cluster_boot_q;
   logic                            cluster_irq_q;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         fc_bootaddr_q  <= soc_ctrl_cfg_pkg::FC_BOOT_RESET;
         fc_fetchen_q   <= 1'b1;  // FC fetches from boot
         cluster_ctrl_q <= soc_ctrl_cfg_pkg::CLUSTER_CTRL_RESET;
         cluster_boot_q <= '0;
         cluster_irq_q  <= 1'b0;
      end
      else if (access_i.wr)
      begin
         case (access_i.id)
            soc_ctrl_map_pkg::FCBOOT:       fc_bootaddr_q         <= access_i.wdata;
            soc_ctrl_map_pkg::FCFETCH:      fc_fetchen_q          <= access_i.wdata[0];
            soc_ctrl_map_pkg::CLUSTER_CTRL: cluster_ctrl_q        <= access_i.wdata[3:0];
            soc_ctrl_map_pkg::CLUSTER_IRQ:  cluster_irq_q         <= access_i.wdata[0];
            soc_ctrl_map_pkg::CL_BOOT0:     cluster_boot_q[31:0]  <= access_i.wdata;
            soc_ctrl_map_pkg::CL_BOOT1:     cluster_boot_q[63:32] <= access_i.wdata;
            default:                        cluster_irq_q         <= cluster_irq_q;
         endcase
      end
   end

   // fetch enable is write-only
   always_comb
   begin
      case (access_i.id)
         soc_ctrl_map_pkg::FCBOOT:       rdata_o = fc_bootaddr_q;
         soc_ctrl_map_pkg::CLUSTER_CTRL: rdata_o = {28'h0, cluster_ctrl_q};
         soc_ctrl_map_pkg::CLUSTER_IRQ:  rdata_o = {31'h0, cluster_irq_q};
         soc_ctrl_map_pkg::CL_BOOT0:     rdata_o = cluster_boot_q[31:0];
         soc_ctrl_map_pkg::CL_BOOT1:     rdata_o = cluster_boot_q[63:32];
         default:                        rdata_o = '0;
      endcase
   end

   assign fc_bootaddr_o       = fc_bootaddr_q;
   assign fc_fetchen_o        = fc_fetchen_q;
   assign cluster_ctrl_o      = cluster_ctrl_q;
   assign cluster_boot_addr_o = cluster_boot_q;
   assign cluster_irq_o       = cluster_irq_q;

endmodule

// ==== hw/soc_status_regs.sv ====
//****************************************
// SoC status registers
// info, core status, clock select, JTAG
//****************************************
module soc_status_regs
(
   input  logic                          HCLK,
   input  logic                          HRESETn,
   input  soc_ctrl_map_pkg::reg_access_t access_i,
   input  logic                          sel_fll_clk_i,
   input  soc_ctrl_cfg_pkg::jtag_reg_t   soc_jtag_reg_i,
   output soc_ctrl_map_pkg::word_t       rdata_o,
   output soc_ctrl_cfg_pkg::jtag_reg_t   soc_jtag_reg_o
);

   soc_ctrl_map_pkg::word_t     corestatus_q;  // eoc in bit 31
   soc_ctrl_cfg_pkg::jtag_reg_t jtag_out_q;
   soc_ctrl_cfg_pkg::jtag_reg_t jtag_meta_q;   // first sync stage
   soc_ctrl_cfg_pkg::jtag_reg_t jtag_sync_q;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         corestatus_q <= '0;
         jtag_out_q   <= '0;
         jtag_meta_q  <= '0;
         jtag_sync_q  <= '0;
      end
      else
      begin
         jtag_meta_q <= soc_jtag_reg_i;  // JTAG side is asynchronous
         jtag_sync_q <= jtag_meta_q;
         if (access_i.wr && access_i.id == soc_ctrl_map_pkg::CORESTATUS)
         begin
            corestatus_q <= access_i.wdata;
         end
         if (access_i.wr && access_i.id == soc_ctrl_map_pkg::JTAGREG)
         begin
            jtag_out_q <= access_i.wdata[7:0];
         end
      end
   end

   always_comb
   begin
      case (access_i.id)
         soc_ctrl_map_pkg::INFO:
            rdata_o = {soc_ctrl_cfg_pkg::NB_CORES, soc_ctrl_cfg_pkg::NB_CLUSTERS};
         soc_ctrl_map_pkg::CORESTATUS: rdata_o = corestatus_q;
         soc_ctrl_map_pkg::CS_RO:      rdata_o = corestatus_q;  // read-only mirror
         soc_ctrl_map_pkg::CLKSEL:     rdata_o = {31'h0, sel_fll_clk_i};
         soc_ctrl_map_pkg::JTAGREG:    rdata_o = {16'h0, jtag_sync_q, jtag_out_q};
         default:                      rdata_o = '0;
      endcase
   end

   assign soc_jtag_reg_o = jtag_out_q;

endmodule

// ==== hw/apb_soc_ctrl.sv ====
//****************************************
// APB SoC control block
// pad muxing, boot, cluster and status
//****************************************
module apb_soc_ctrl
(
   input  logic                            HCLK,
   input  logic                            HRESETn,
   input  soc_ctrl_map_pkg::paddr_t        paddr_i,
   input  soc_ctrl_map_pkg::word_t         pwdata_i,
   input  logic                            pwrite_i,
   input  logic                            psel_i,
   input  logic                            penable_i,
   output soc_ctrl_map_pkg::word_t         prdata_o,
   output logic                            pready_o,
   output logic                            pslverr_o,
   input  logic                            sel_fll_clk_i,
   input  soc_ctrl_cfg_pkg::jtag_reg_t     soc_jtag_reg_i,
   output soc_ctrl_cfg_pkg::jtag_reg_t     soc_jtag_reg_o,
   output soc_ctrl_cfg_pkg::pad_fun_t [soc_ctrl_cfg_pkg::N_PADS-1:0] pad_mux_o,
   output soc_ctrl_cfg_pkg::pad_cfg_t [soc_ctrl_cfg_pkg::N_PADS-1:0] pad_cfg_o,
   output soc_ctrl_map_pkg::word_t         fc_bootaddr_o,
   output logic                            fc_fetchen_o,
   output soc_ctrl_cfg_pkg::cluster_ctrl_t cluster_ctrl_o,
   output soc_ctrl_cfg_pkg::boot_addr_t    cluster_boot_addr_o,
   output logic                            cluster_irq_o
);

   soc_ctrl_map_pkg::reg_access_t access;
   soc_ctrl_map_pkg::word_t       pad_rdata;
   soc_ctrl_map_pkg::word_t       boot_rdata;
   soc_ctrl_map_pkg::word_t       status_rdata;

   apb_reg_decode u_decode (
      .paddr_i        (paddr_i),
      .pwdata_i       (pwdata_i),
      .pwrite_i       (pwrite_i),
      .psel_i         (psel_i),
      .penable_i      (penable_i),
      .pad_rdata_i    (pad_rdata),
      .boot_rdata_i   (boot_rdata),
      .status_rdata_i (status_rdata),
      .access_o       (access),
      .prdata_o       (prdata_o)
   );

   pad_ctrl_regs u_pads (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .access_i  (access),
      .rdata_o   (pad_rdata),
      .pad_mux_o (pad_mux_o),
      .pad_cfg_o (pad_cfg_o)
   );

   boot_cluster_regs u_boot (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .access_i            (access),
      .rdata_o             (boot_rdata),
      .fc_bootaddr_o       (fc_bootaddr_o),
      .fc_fetchen_o        (fc_fetchen_o),
      .cluster_ctrl_o      (cluster_ctrl_o),
      .cluster_boot_addr_o (cluster_boot_addr_o),
      .cluster_irq_o       (cluster_irq_o)
   );

   soc_status_regs u_status (
      .HCLK           (HCLK),
      .HRESETn        (HRESETn),
      .access_i       (access),
      .sel_fll_clk_i  (sel_fll_clk_i),
      .soc_jtag_reg_i (soc_jtag_reg_i),
      .rdata_o        (status_rdata),
      .soc_jtag_reg_o (soc_jtag_reg_o)
   );

   assign pready_o  = 1'b1;  // zero wait states
   assign pslverr_o = 1'b0;

endmodule

// ==== tb/apb_soc_ctrl_chk.sv ====
//****************************************
// bus response and cluster control checks
//****************************************
module apb_soc_ctrl_chk
(
   input logic                            HCLK,
   input logic                            HRESETn,
   input soc_ctrl_map_pkg::paddr_t        paddr_i,
   input logic                            psel_i,
   input logic                            penable_i,
   input logic                            pwrite_i,
   input logic                            pready_i,
   input logic                            pslverr_i,
   input soc_ctrl_cfg_pkg::cluster_ctrl_t cluster_ctrl_i
);

   timeunit 1ns;
   timeprecision 100ps;

   logic cluster_wr;  // access phase of a cluster-control write

   assign cluster_wr = psel_i & penable_i & pwrite_i &
                       (paddr_i[8:2] == soc_ctrl_map_pkg::IDX_CLUSTER_CTRL);

   a_ready: assert property (@(posedge HCLK) disable iff (!HRESETn) pready_i)
      else $error("pready_o went low");

   a_no_slverr: assert property (@(posedge HCLK) disable iff (!HRESETn) !pslverr_i)
      else $error("pslverr_o went high");

   a_cluster_wr: assert property (@(posedge HCLK) disable iff (!HRESETn)
      (cluster_ctrl_i != $past(cluster_ctrl_i)) |-> $past(cluster_wr))
      else $error("cluster_ctrl_o changed without a cluster-control write");

endmodule

bind apb_soc_ctrl apb_soc_ctrl_chk u_chk (
   .HCLK           (HCLK),
   .HRESETn        (HRESETn),
   .paddr_i        (paddr_i),
   .psel_i         (psel_i),
   .penable_i      (penable_i),
   .pwrite_i       (pwrite_i),
   .pready_i       (pready_o),
   .pslverr_i      (pslverr_o),
   .cluster_ctrl_i (cluster_ctrl_o)
);

// ==== tb/tb_apb_soc_ctrl.sv ====
//****************************************
// testbench for the APB SoC control block
// file-driven bus accesses, typed checks
//****************************************
module tb_apb_soc_ctrl;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int ACCESS_TIMEOUT = 16;
   localparam int JTAG_TIMEOUT   = 10;

   logic                            HCLK;
   logic                            HRESETn;
   soc_ctrl_map_pkg::paddr_t        paddr;
   soc_ctrl_map_pkg::word_t         pwdata;
   logic                            pwrite;
   logic                            psel;
   logic                            penable;
   soc_ctrl_map_pkg::word_t         prdata;
   logic                            pready;
   logic                            pslverr;
   logic                            sel_fll_clk;
   soc_ctrl_cfg_pkg::jtag_reg_t     jtag_in;
   soc_ctrl_cfg_pkg::jtag_reg_t     jtag_out;
   soc_ctrl_cfg_pkg::pad_fun_t [soc_ctrl_cfg_pkg::N_PADS-1:0] pad_mux;
   soc_ctrl_cfg_pkg::pad_cfg_t [soc_ctrl_cfg_pkg::N_PADS-1:0] pad_cfg;
   soc_ctrl_map_pkg::word_t         fc_bootaddr;
   logic                            fc_fetchen;
   soc_ctrl_cfg_pkg::cluster_ctrl_t cluster_ctrl;
   soc_ctrl_cfg_pkg::boot_addr_t    cluster_boot_addr;
   logic                            cluster_irq;

   int errors;
   int checks;

   apb_soc_ctrl u_apb_soc_ctrl (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .paddr_i             (paddr),
      .pwdata_i            (pwdata),
      .pwrite_i            (pwrite),
      .psel_i              (psel),
      .penable_i           (penable),
      .prdata_o            (prdata),
      .pready_o            (pready),
      .pslverr_o           (pslverr),
      .sel_fll_clk_i       (sel_fll_clk),
      .soc_jtag_reg_i      (jtag_in),
      .soc_jtag_reg_o      (jtag_out),
      .pad_mux_o           (pad_mux),
      .pad_cfg_o           (pad_cfg),
      .fc_bootaddr_o       (fc_bootaddr),
      .fc_fetchen_o        (fc_fetchen),
      .cluster_ctrl_o      (cluster_ctrl),
      .cluster_boot_addr_o (cluster_boot_addr),
      .cluster_irq_o       (cluster_irq)
   );

   always #20 HCLK = ~HCLK;  // 40 ns period

   task automatic check_word(input string name, input soc_ctrl_map_pkg::word_t exp,
                             input soc_ctrl_map_pkg::word_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("** Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_pad_cfg(input string name, input soc_ctrl_cfg_pkg::pad_cfg_t exp,
                                input soc_ctrl_cfg_pkg::pad_cfg_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("** Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_cluster(input string name, input soc_ctrl_cfg_pkg::cluster_ctrl_t exp,
                                input soc_ctrl_cfg_pkg::cluster_ctrl_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("** Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // setup phase, then access phase until pready
   task automatic bus_access(input string name, input soc_ctrl_map_pkg::paddr_t addr,
                             input logic write, input soc_ctrl_map_pkg::word_t wdata,
                             output soc_ctrl_map_pkg::word_t rdata);
      int waited;
      @(posedge HCLK);
      paddr   <= addr;
      pwrite  <= write;
      pwdata  <= wdata;
      psel    <= 1'b1;
      penable <= 1'b0;
      @(posedge HCLK);
      penable <= 1'b1;
      waited = 0;
      @(negedge HCLK);
      while (!pready && waited < ACCESS_TIMEOUT)
      begin
         @(negedge HCLK);
         waited++;
      end
      if (!pready)
      begin
         errors++;
         $display("bus access to %h got no ready within %0d cycles", addr, ACCESS_TIMEOUT);
      end
      check_word({name, "_slverr"}, 32'h0, {31'h0, pslverr});  // bus never errors
      rdata = prdata;
      @(posedge HCLK);  // access edge, write lands here
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic check_write_outputs(input string name, input soc_ctrl_map_pkg::paddr_t addr,
                                      input soc_ctrl_map_pkg::word_t data);
      soc_ctrl_map_pkg::reg_idx_t idx;
      soc_ctrl_map_pkg::word_t    got;
      logic [5:0]                 pin;
      idx = addr[8:2];
      got = '0;
      if (idx >= soc_ctrl_map_pkg::IDX_PADFUN_BASE &&
          idx < soc_ctrl_map_pkg::IDX_PADFUN_BASE + soc_ctrl_map_pkg::N_PADFUN_REGS)
      begin
         for (int k = 0; k < 16; k++)
         begin
            pin = 6'(16 * int'(idx - soc_ctrl_map_pkg::IDX_PADFUN_BASE) + k);
            got[2*k +: 2] = pad_mux[pin];  // pin 16*group+k
         end
         check_word({name, "_mux"}, data, got);
      end
      else if (idx >= soc_ctrl_map_pkg::IDX_PADCFG_BASE &&
               idx < soc_ctrl_map_pkg::IDX_PADCFG_BASE + soc_ctrl_map_pkg::N_PADCFG_REGS)
      begin
         for (int k = 0; k < 4; k++)
         begin
            pin = 6'(4 * int'(idx - soc_ctrl_map_pkg::IDX_PADCFG_BASE) + k);
            check_pad_cfg({name, "_cfg"}, data[8*k +: 6], pad_cfg[pin]);
         end
      end
      else
      begin
         case (idx)
            soc_ctrl_map_pkg::IDX_FCBOOT:       check_word(name, data, fc_bootaddr);
            soc_ctrl_map_pkg::IDX_FCFETCH:
               check_word(name, {31'h0, data[0]}, {31'h0, fc_fetchen});
            soc_ctrl_map_pkg::IDX_CLUSTER_CTRL: check_cluster(name, data[3:0], cluster_ctrl);
            soc_ctrl_map_pkg::IDX_CLUSTER_IRQ:
               check_word(name, {31'h0, data[0]}, {31'h0, cluster_irq});
            soc_ctrl_map_pkg::IDX_JTAGREG:
               check_word(name, {24'h0, data[7:0]}, {24'h0, jtag_out});
            soc_ctrl_map_pkg::IDX_CL_BOOT0:     check_word(name, data, cluster_boot_addr[31:0]);
            soc_ctrl_map_pkg::IDX_CL_BOOT1:     check_word(name, data, cluster_boot_addr[63:32]);
            default:                            ;
         endcase
      end
   endtask

   // JTAG input passes two sync flops before readback
   task automatic drive_jtag(input string name, input soc_ctrl_cfg_pkg::jtag_reg_t value,
                             input logic clksel);
      int waited;
      @(posedge HCLK);
      jtag_in     <= value;
      sel_fll_clk <= clksel;
      paddr       <= {3'b000, soc_ctrl_map_pkg::IDX_JTAGREG, 2'b00};
      waited = 0;
      checks++;
      @(negedge HCLK);
      while (prdata[15:8] !== value && waited < JTAG_TIMEOUT)
      begin
         @(negedge HCLK);
         waited++;
      end
      if (prdata[15:8] !== value)
      begin
         errors++;
         $display("%s: JTAG input did not reach readback within %0d cycles", name, JTAG_TIMEOUT);
      end
   endtask

   task automatic check_reset_outputs();
      check_cluster("reset_cluster_out", 4'b1001, cluster_ctrl);  // rstn and byp
      check_pad_cfg("reset_pad0_cfg", 6'h3F, pad_cfg[0]);
      check_pad_cfg("reset_pad63_cfg", 6'h3F, pad_cfg[63]);
      check_word("reset_pad_mux", 32'h0, pad_mux[15:0]);
      check_word("reset_fc_boot_out", 32'h1A00_0000, fc_bootaddr);
      check_word("reset_fc_fetch_out", 32'h1, {31'h0, fc_fetchen});
      check_word("reset_cl_boot_out", 32'h0, cluster_boot_addr[31:0] | cluster_boot_addr[63:32]);
      check_word("reset_jtag_out", 32'h0, {24'h0, jtag_out});
   endtask

   initial
   begin
      int                      fd;
      string                   line;
      string                   op;
      string                   name;
      soc_ctrl_map_pkg::word_t a;
      soc_ctrl_map_pkg::word_t d;
      soc_ctrl_map_pkg::word_t rd;
      HCLK        = 1'b0;
      HRESETn     = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      pwrite      = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      sel_fll_clk = 1'b0;
      jtag_in     = '0;
      errors      = 0;
      checks      = 0;
      repeat (5) @(posedge HCLK);
      HRESETn <= 1'b1;
      @(negedge HCLK);
      check_reset_outputs();
      fd = $fopen("tb/soc_ctrl_tests.txt", "r");
      if (fd == 0)
      begin
         errors++;
         $display("could not open the test data file tb/soc_ctrl_tests.txt");
      end
      else
      begin
         while ($fgets(line, fd) != 0)
         begin
            if (line.len() < 2 || line.getc(0) == "#")
               continue;
            if ($sscanf(line, "%s %s %h %h", op, name, a, d) != 4)
            begin
               errors++;
               $display("test data line could not be parsed: %s", line);
               continue;
            end
            if (op == "W")
            begin
               bus_access(name, a[11:0], 1'b1, d, rd);
               @(negedge HCLK);  // outputs settled after the access edge
               check_write_outputs(name, a[11:0], d);
            end
            else if (op == "R")
            begin
               bus_access(name, a[11:0], 1'b0, '0, rd);
               check_word(name, d, rd);
            end
            else if (op == "J")
               drive_jtag(name, a[7:0], d[0]);
            else
            begin
               errors++;
               $display("unknown operation %s in test %s", op, name);
            end
         end
         $fclose(fd);
      end
      $display("errors: %0d, checks: %0d", errors, checks);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// ==== tb/soc_ctrl_tests.txt ====
# op name addr data, hex; W writes data, R expects data at addr
# J drives the JTAG input (third column) and clock select (fourth column)
R reset_fcboot 004 1A000000
R reset_cluster_ctrl 070 00000009
R reset_padcfg 020 3F3F3F3F
R reset_info 000 00040000
R bootsel_gone 00C 00000000
W padfun2_wr 018 E4E41B1B
R padfun2_rd 018 E4E41B1B
R padfun0_rd 010 00000000
R padfun1_rd 014 00000000
R padfun3_rd 01C 00000000
W padcfg5_wr 034 FFFFFFFF
R padcfg5_rd 034 3F3F3F3F
W padcfg6_wr 038 15002A07
R padcfg6_rd 038 15002A07
R padcfg4_rd 030 3F3F3F3F
W cluster_ctrl_wr 070 0000000E
R cluster_ctrl_rd 070 0000000E
W cluster_ctrl_wr2 070 FFFFFFF5
R cluster_ctrl_rd2 070 00000005
W cl_boot_lo_wr 080 1C008080
W cl_boot_hi_wr 084 00000001
R cl_boot_lo_rd 080 1C008080
R cl_boot_hi_rd 084 00000001
W fcboot_wr 004 1C000000
R fcboot_rd 004 1C000000
W fcfetch_off 008 00000000
W fcfetch_on 008 00000001
R fcfetch_rd 008 00000000
W irq_wr 07C 00000001
R irq_rd 07C 00000001
W corestatus_wr 0A0 80000042
R corestatus_rd 0A0 80000042
R cs_ro_rd 0C0 80000042
W cs_ro_wr 0C0 DEADBEEF
R cs_ro_rd2 0C0 80000042
J jtag_in_a5 A5 1
R clksel_rd 0C8 00000001
W jtag_out_wr 074 0000003C
R jtag_rd 074 0000A53C
W unmapped_wr 0E0 12345678
R unmapped_rd 0E0 00000000

// ==== sources.f ====
hw/soc_ctrl_map_pkg.sv
hw/soc_ctrl_cfg_pkg.sv
hw/apb_reg_decode.sv
hw/pad_ctrl_regs.sv
hw/boot_cluster_regs.sv
hw/soc_status_regs.sv
hw/apb_soc_ctrl.sv
tb/apb_soc_ctrl_chk.sv
tb/tb_apb_soc_ctrl.sv

// ==== Makefile ====
# Verilator build and run for the APB SoC control block

VERILATOR ?= verilator
TOP       ?= tb_apb_soc_ctrl
FILELIST  ?= sources.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@! grep -q "Test failed" $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
